//--- hw/conv_out_config.svh
`ifndef CONV_OUT_CONFIG_SVH
`define CONV_OUT_CONFIG_SVH

// lanes per beat, one per MAC column
`define COLS_MAC 4

// word address of the output feature memory
`define ADDR_BITS 10

// datapath widths
`define MAC_BITS 32
`define PIX_BITS 8

// cycles from a beat to its memory write
// requant register, old-value read, write
`define ACC_LAT 3

// lower bound on beats per channel
// keeps the partial-sum read of a word behind its own write
`define MIN_CHANNEL_BEATS 4

`endif

//--- hw/conv_types_pkg.sv
`default_nettype none

`include "conv_out_config.svh"

package conv_types_pkg;

	// ####################################################################
	// lane data
	// ####################################################################

	typedef logic signed [`MAC_BITS-1:0] mac_t;
	typedef logic signed [`PIX_BITS-1:0] pix_t;

	// one bit wider than a pixel, clamped again after the add
	typedef logic signed [`PIX_BITS:0] zq_t;

	typedef mac_t [`COLS_MAC-1:0] mac_lanes_t;
	typedef zq_t [`COLS_MAC-1:0] zq_lanes_t;

	// one feature memory word
	typedef pix_t [`COLS_MAC-1:0] pix_lanes_t;

	// ####################################################################
	// layer configuration and control
	// ####################################################################

	typedef struct packed {
		logic [7:0] channels;
		logic [7:0] row_len;
		logic [7:0] groups;
		logic [7:0] n;
		logic [7:0] frac;
		mac_t bias;
		logic [7:0] base;
	} cfg_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		RUN,
		DRAIN,
		DONE
	} seq_state_t;

endpackage

`default_nettype wire

//--- hw/of_bus_pkg.sv
`default_nettype none

`include "conv_out_config.svh"

package of_bus_pkg;

	// word address, shared by all lane banks
	typedef logic [`ADDR_BITS-1:0] of_addr_t;

	// read port owners, ACC has priority
	typedef enum logic {
		ACC,
		HOST
	} requester_t;

endpackage

`default_nettype wire

//--- hw/of_bus_if.sv
`default_nettype none

`include "conv_out_config.svh"

interface of_bus_if
	import of_bus_pkg::*;
();

	// read side
	logic rd_en;
	of_addr_t rd_addr;
	logic rd_gnt;
	logic [`COLS_MAC*`PIX_BITS-1:0] rd_data;

	// write side, completes in the cycle it is presented
	logic wr_en;
	of_addr_t wr_addr;
	logic [`COLS_MAC*`PIX_BITS-1:0] wr_data;

	modport requester (
		output rd_en,
		output rd_addr,
		input rd_gnt,
		input rd_data,
		output wr_en,
		output wr_addr,
		output wr_data
	);

	modport memory (
		input rd_en,
		input rd_addr,
		output rd_gnt,
		output rd_data,
		input wr_en,
		input wr_addr,
		input wr_data
	);

endinterface

`default_nettype wire

//--- hw/layer_sequencer.sv
`default_nettype none

`include "conv_out_config.svh"

module layer_sequencer
	import conv_types_pkg::*, of_bus_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input cfg_t cfg,
	input logic mac_valid,
	input mac_lanes_t mac_result,
	output logic beat,
	output mac_lanes_t beat_mac,
	output of_addr_t beat_addr,
	output logic first_ch,
	output logic last_ch,
	output cfg_t cfg_q,
	output logic busy,
	output logic next_channel,
	output logic done
);

	localparam int DRAIN_W = $clog2(`ACC_LAT);
	localparam int DRAIN_LAST = `ACC_LAT - 2;

	seq_state_t state;
	logic [15:0] beat_cnt;
	logic [15:0] ch_beats;
	logic [7:0] ch_cnt;
	logic [DRAIN_W-1:0] drain_cnt;
	logic beat_last;

	// beats per channel
	assign ch_beats = 16'(cfg_q.row_len) * 16'(cfg_q.groups);
	assign beat_last = (beat_cnt == ch_beats - 16'd1);

	// beat tagging, same cycle as mac_valid
	assign beat = mac_valid && (state == RUN);
	assign beat_mac = mac_result;
	assign beat_addr = of_addr_t'(cfg_q.base) + of_addr_t'(beat_cnt);
	assign first_ch = (ch_cnt == 8'd0);
	assign last_ch = (ch_cnt == cfg_q.channels - 8'd1);

	assign next_channel = beat && beat_last;
	assign busy = (state == LOAD) || (state == RUN) || (state == DRAIN);
	assign done = (state == DONE);

	// configuration register
	always_ff @(posedge clk) begin
		if (state == LOAD) begin
			cfg_q <= cfg;
		end
	end

	// ####################################################################
	// layer FSM
	// ####################################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			beat_cnt <= '0;
			ch_cnt <= '0;
			drain_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						state <= LOAD;
					end
				end
				LOAD: begin
					beat_cnt <= '0;
					ch_cnt <= '0;
					state <= RUN;
				end
				RUN: begin
					if (beat) begin
						if (beat_last) begin
							beat_cnt <= '0;
							if (last_ch) begin
								drain_cnt <= '0;
								state <= DRAIN;
							end else begin
								ch_cnt <= ch_cnt + 8'd1;
							end
						end else begin
							beat_cnt <= beat_cnt + 16'd1;
						end
					end
				end
				DRAIN: begin
					// let the last beat reach the memory
					if (drain_cnt == DRAIN_W'(DRAIN_LAST)) begin
						state <= DONE;
					end else begin
						drain_cnt <= drain_cnt + 1'b1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	a_beats_in_run: assert property (@(posedge clk) disable iff (rst)
		mac_valid |-> state == RUN)
		else $error("mac_valid outside RUN");

	a_min_beats: assert property (@(posedge clk) disable iff (rst)
		state == LOAD |->
			16'(cfg.row_len) * 16'(cfg.groups) >= 16'(`MIN_CHANNEL_BEATS))
		else $error("too few beats per channel");

endmodule

`default_nettype wire

//--- hw/requant_lanes.sv
`default_nettype none

`include "conv_out_config.svh"

module requant_lanes
	import conv_types_pkg::*, of_bus_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic beat,
	input mac_lanes_t beat_mac,
	input of_addr_t beat_addr,
	input logic first_ch,
	input logic last_ch,
	input cfg_t cfg_q,
	output logic q_valid,
	output zq_lanes_t q_lanes,
	output zq_t q_bias,
	output of_addr_t q_addr,
	output logic q_first,
	output logic q_last
);

	// shift, fixed-point multiply, floor by 2^16, clamp to 9 bits
	function automatic zq_t requant(input mac_t v, input logic [7:0] n,
			input logic [7:0] frac);
		logic signed [32:0] aux;
		logic signed [8:0] f9;
		logic signed [55:0] prod;
		logic signed [39:0] q;
		aux = 33'sd1 + (33'(v) >>> n);
		f9 = {1'b0, frac};
		prod = 56'(aux) * 56'(f9) * 56'sd256 + 56'sd1;
		q = 40'(prod >>> 16);
		if (q > 40'sd255) begin
			return 9'sd255;
		end else if (q < -40'sd256) begin
			return -9'sd256;
		end
		return q[8:0];
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			q_valid <= 1'b0;
		end else begin
			q_valid <= beat;
		end
	end

	// payload follows the strobe
	always_ff @(posedge clk) begin
		for (int i = 0; i < `COLS_MAC; i++) begin
			q_lanes[i] <= requant(beat_mac[i], cfg_q.n, cfg_q.frac);
		end
		q_bias <= requant(cfg_q.bias, cfg_q.n, cfg_q.frac);
		q_addr <= beat_addr;
		q_first <= first_ch;
		q_last <= last_ch;
	end

endmodule

`default_nettype wire

//--- hw/of_accumulator.sv
`default_nettype none

`include "conv_out_config.svh"

module of_accumulator
	import conv_types_pkg::*, of_bus_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic q_valid,
	input zq_lanes_t q_lanes,
	input zq_t q_bias,
	input of_addr_t q_addr,
	input logic q_first,
	input logic q_last,
	of_bus_if.requester bus
);

	// beat waiting for its old value
	logic p_valid;
	logic p_first;
	logic p_last;
	of_addr_t p_addr;
	zq_lanes_t p_lanes;
	zq_t p_bias;

	// beat being written
	logic w_en;
	of_addr_t w_addr;
	pix_lanes_t w_data;

	pix_lanes_t old_pix;
	pix_lanes_t sum_pix;

	// the first channel starts from the bias, no read
	assign bus.rd_en = q_valid && !q_first;
	assign bus.rd_addr = q_addr;
	assign old_pix = bus.rd_data;

	always_comb begin
		zq_t addend;
		logic signed [9:0] sum;
		for (int i = 0; i < `COLS_MAC; i++) begin
			addend = p_first ? p_bias : zq_t'(old_pix[i]);
			sum = 10'(p_lanes[i]) + 10'(addend);
			if (sum > 10'sd127) begin
				sum_pix[i] = 8'sd127;
			end else if (sum < -10'sd128) begin
				sum_pix[i] = -8'sd128;
			end else begin
				sum_pix[i] = sum[7:0];
			end
			// ReLU on the last channel
			if (p_last && sum_pix[i] < 0) begin
				sum_pix[i] = '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			p_valid <= 1'b0;
			w_en <= 1'b0;
		end else begin
			p_valid <= q_valid;
			w_en <= p_valid;
		end
	end

	always_ff @(posedge clk) begin
		p_first <= q_first;
		p_last <= q_last;
		p_addr <= q_addr;
		p_lanes <= q_lanes;
		p_bias <= q_bias;
		w_addr <= p_addr;
		w_data <= sum_pix;
	end

	assign bus.wr_en = w_en;
	assign bus.wr_addr = w_addr;
	assign bus.wr_data = w_data;

	// the old value must have been read in the cycle before
	a_read_on_time: assert property (@(posedge clk) disable iff (rst)
		p_valid && !p_first |-> $past(bus.rd_gnt))
		else $error("partial sum read not granted in time");

endmodule

`default_nettype wire

//--- hw/of_store.sv
`default_nettype none

`include "conv_out_config.svh"

module of_store
	import conv_types_pkg::*, of_bus_pkg::*;
(
	input logic clk,
	input logic rst,
	of_bus_if.memory acc_bus,
	of_bus_if.memory host_bus
);

	localparam int DEPTH = 1 << `ADDR_BITS;

	// one bank per lane, all on the same word address
	pix_t mem [`COLS_MAC][DEPTH];

	pix_lanes_t rd_q;
	pix_lanes_t wr_word;
	requester_t rd_owner;
	of_addr_t rd_addr;
	logic rd_any;

	// ####################################################################
	// read arbitration, ACC over HOST
	// ####################################################################

	assign rd_owner = acc_bus.rd_en ? ACC : HOST;
	assign rd_addr = (rd_owner == ACC) ? acc_bus.rd_addr : host_bus.rd_addr;
	assign rd_any = acc_bus.rd_en || host_bus.rd_en;

	assign acc_bus.rd_gnt = acc_bus.rd_en;
	assign host_bus.rd_gnt = host_bus.rd_en && (rd_owner == HOST);

	assign wr_word = acc_bus.wr_data;

	always_ff @(posedge clk) begin
		for (int i = 0; i < `COLS_MAC; i++) begin
			if (acc_bus.wr_en) begin
				mem[i][acc_bus.wr_addr] <= wr_word[i];
			end
			if (rd_any) begin
				rd_q[i] <= mem[i][rd_addr];
			end
		end
	end

	// shared read register, the grant tells who owns it
	assign acc_bus.rd_data = rd_q;
	assign host_bus.rd_data = rd_q;

	a_one_grant: assert property (@(posedge clk) disable iff (rst)
		!(acc_bus.rd_gnt && host_bus.rd_gnt))
		else $error("two read grants");

	a_host_no_write: assert property (@(posedge clk) disable iff (rst)
		!host_bus.wr_en)
		else $error("host bus write");

endmodule

`default_nettype wire

//--- hw/host_readout.sv
`default_nettype none

module host_readout
	import conv_types_pkg::*, of_bus_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic rd_en,
	input of_addr_t rd_addr,
	output pix_lanes_t rd_data,
	output logic rd_valid,
	of_bus_if.requester bus
);

	logic pend;
	of_addr_t pend_addr;
	logic take;

	// new request once the old one is gone or granted now
	assign take = rd_en && (!pend || bus.rd_gnt);

	always_ff @(posedge clk) begin
		if (rst) begin
			pend <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= pend && bus.rd_gnt;
			if (take) begin
				pend <= 1'b1;
			end else if (bus.rd_gnt) begin
				pend <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			pend_addr <= rd_addr;
		end
	end

	assign bus.rd_en = pend;
	assign bus.rd_addr = pend_addr;
	assign rd_data = bus.rd_data;

	// read-only requester
	assign bus.wr_en = 1'b0;
	assign bus.wr_addr = '0;
	assign bus.wr_data = '0;

endmodule

`default_nettype wire

//--- hw/conv_out_top.sv
`default_nettype none

module conv_out_top
	import conv_types_pkg::*, of_bus_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input cfg_t cfg,
	input logic mac_valid,
	input mac_lanes_t mac_result,
	output logic busy,
	output logic next_channel,
	output logic done,
	input logic rd_en,
	input of_addr_t rd_addr,
	output pix_lanes_t rd_data,
	output logic rd_valid
);

	// sequencer to requant
	logic beat;
	mac_lanes_t beat_mac;
	of_addr_t beat_addr;
	logic first_ch;
	logic last_ch;
	cfg_t cfg_q;

	// requant to accumulator
	logic q_valid;
	zq_lanes_t q_lanes;
	zq_t q_bias;
	of_addr_t q_addr;
	logic q_first;
	logic q_last;

	of_bus_if acc_bus ();
	of_bus_if host_bus ();

	layer_sequencer layer_sequencer_inst (
		.clk(clk),
		.rst(rst),
		.start(start),
		.cfg(cfg),
		.mac_valid(mac_valid),
		.mac_result(mac_result),
		.beat(beat),
		.beat_mac(beat_mac),
		.beat_addr(beat_addr),
		.first_ch(first_ch),
		.last_ch(last_ch),
		.cfg_q(cfg_q),
		.busy(busy),
		.next_channel(next_channel),
		.done(done)
	);

	requant_lanes requant_lanes_inst (
		.clk(clk),
		.rst(rst),
		.beat(beat),
		.beat_mac(beat_mac),
		.beat_addr(beat_addr),
		.first_ch(first_ch),
		.last_ch(last_ch),
		.cfg_q(cfg_q),
		.q_valid(q_valid),
		.q_lanes(q_lanes),
		.q_bias(q_bias),
		.q_addr(q_addr),
		.q_first(q_first),
		.q_last(q_last)
	);

	of_accumulator of_accumulator_inst (
		.clk(clk),
		.rst(rst),
		.q_valid(q_valid),
		.q_lanes(q_lanes),
		.q_bias(q_bias),
		.q_addr(q_addr),
		.q_first(q_first),
		.q_last(q_last),
		.bus(acc_bus.requester)
	);

	of_store of_store_inst (
		.clk(clk),
		.rst(rst),
		.acc_bus(acc_bus.memory),
		.host_bus(host_bus.memory)
	);

	host_readout host_readout_inst (
		.clk(clk),
		.rst(rst),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.bus(host_bus.requester)
	);

endmodule

`default_nettype wire

//--- tb/conv_out_ref.svh
`ifndef CONV_OUT_REF_SVH
`define CONV_OUT_REF_SVH

// ######################################################################
// reference model
// ######################################################################

// shift, scale by frac, floor by 2^16, clamp to the 9-bit range
function automatic int requant_ref(input longint v, input int n, input int frac);
	longint aux;
	longint prod;
	longint q;
	aux = 64'sd1 + (v >>> n);
	prod = aux * frac * 256 + 1;
	q = prod / 65536;
	// division truncates toward zero, floor steps down once more
	if (prod < 0 && prod % 65536 != 0) begin
		q = q - 1;
	end
	if (q > 255) begin
		q = 255;
	end else if (q < -256) begin
		q = -256;
	end
	return int'(q);
endfunction

// expected memory image after one layer built from stim
function automatic void layer_ref(input cfg_t c);
	int beats;
	int z_bias;
	int s;
	of_addr_t a;
	pix_lanes_t word;
	beats = int'(c.row_len) * int'(c.groups);
	z_bias = requant_ref($signed(c.bias), int'(c.n), int'(c.frac));
	for (int ch = 0; ch < int'(c.channels); ch++) begin
		for (int b = 0; b < beats; b++) begin
			a = of_addr_t'(int'(c.base) + b);
			word = exp_mem[a];
			for (int i = 0; i < `COLS_MAC; i++) begin
				s = requant_ref($signed(stim[ch * beats + b][i]), int'(c.n), int'(c.frac));
				// bias on the first channel, stored partial sum after it
				if (ch == 0) begin
					s = s + z_bias;
				end else begin
					s = s + int'($signed(word[i]));
				end
				if (s > 127) begin
					s = 127;
				end else if (s < -128) begin
					s = -128;
				end
				// ReLU
				if (ch == int'(c.channels) - 1 && s < 0) begin
					s = 0;
				end
				word[i] = pix_t'(s);
			end
			exp_mem[a] = word;
			exp_set[a] = 1'b1;
		end
	end
endfunction

// ######################################################################
// compare tasks
// ######################################################################

task automatic check_pix_lanes(input string name, input pix_lanes_t got,
		input pix_lanes_t exp);
	if (got !== exp) begin
		data_errors++;
		$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		status_errors++;
		$display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, got, exp);
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp) begin
		status_errors++;
		$display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
	end
endtask

`endif

//--- tb/conv_out_tb.sv
`default_nettype none

`include "conv_out_config.svh"

module conv_out_tb
	import conv_types_pkg::*, of_bus_pkg::*;
();

	localparam int NEVER = 32'h7fff_ffff;
	localparam int DEPTH = 1 << `ADDR_BITS;

	logic clk;
	logic rst;
	logic start;
	cfg_t cfg;
	logic mac_valid;
	mac_lanes_t mac_result;
	logic busy;
	logic next_channel;
	logic done;
	logic rd_en;
	of_addr_t rd_addr;
	pix_lanes_t rd_data;
	logic rd_valid;

	// beat tags that travel with mac_valid
	logic chan_end;
	logic final_beat;

	integer seed;
	int cycle = 0;
	int limit;
	int data_errors = 0;
	int status_errors = 0;

	// monitor state
	int start_cycle = 0;
	int end_cycle = 0;
	int rd_en_cycle = -10;
	int nc_count = 0;

	mac_lanes_t stim[$];
	pix_lanes_t exp_mem [DEPTH];
	bit exp_set [DEPTH];
	pix_lanes_t exp_q[$];
	of_addr_t addr_q[$];

	`include "conv_out_ref.svh"

	conv_out_top conv_out_top_inst (
		.clk(clk),
		.rst(rst),
		.start(start),
		.cfg(cfg),
		.mac_valid(mac_valid),
		.mac_result(mac_result),
		.busy(busy),
		.next_channel(next_channel),
		.done(done),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.rd_valid(rd_valid)
	);

	always #2 clk = ~clk;

	// ##################################################################
	// stimulus tasks
	// ##################################################################

	task automatic make_stim(input cfg_t c, input bit big);
		integer r;
		mac_lanes_t lanes;
		int total;
		total = int'(c.channels) * int'(c.row_len) * int'(c.groups);
		stim.delete();
		for (int k = 0; k < total; k++) begin
			for (int i = 0; i < `COLS_MAC; i++) begin
				r = $random(seed);
				// full-range values hit both clamps
				if (big && r[0]) begin
					lanes[i] = $random(seed);
				end else begin
					lanes[i] = r % 8192;
				end
			end
			stim.push_back(lanes);
		end
	endtask

	// entered right after a rising edge, returns on the done sample
	task automatic run_layer(input cfg_t c, input bit gaps, input bit big);
		int beats;
		int total;
		make_stim(c, big);
		layer_ref(c);
		beats = int'(c.row_len) * int'(c.groups);
		total = int'(c.channels) * beats;
		cfg <= c;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		do @(posedge clk); while (!busy);
		for (int k = 0; k < total; k++) begin
			if (gaps && ($random(seed) & 3) == 0) begin
				mac_valid <= 1'b0;
				repeat (1 + ($random(seed) & 1)) @(posedge clk);
			end
			mac_valid <= 1'b1;
			mac_result <= stim[k];
			chan_end <= ((k % beats) == beats - 1);
			final_beat <= (k == total - 1);
			@(posedge clk);
		end
		mac_valid <= 1'b0;
		chan_end <= 1'b0;
		final_beat <= 1'b0;
		do @(posedge clk); while (!done);
	endtask

	task automatic read_word(input of_addr_t a);
		rd_en <= 1'b1;
		rd_addr <= a;
		exp_q.push_back(exp_mem[a]);
		addr_q.push_back(a);
		@(posedge clk);
		rd_en <= 1'b0;
		do @(posedge clk); while (!rd_valid);
	endtask

	// every word that some layer has written
	task automatic read_set();
		for (int a = 0; a < 256; a++) begin
			if (exp_set[a]) begin
				read_word(of_addr_t'(a));
			end
		end
	endtask

	// ##################################################################
	// scoreboard
	// ##################################################################

	always @(posedge clk) begin
		pix_lanes_t exp_word;
		of_addr_t exp_addr;
		cycle <= cycle + 1;
		if (!rst) begin
			check_bit("busy", busy, (cycle > start_cycle) && (cycle < end_cycle));
			check_bit("done", done, cycle == end_cycle);
			check_bit("next_channel", next_channel, mac_valid && chan_end);
			check_bit("rd_valid", rd_valid, cycle == rd_en_cycle + 2);
			if (done) begin
				check_count("next_channel pulses", nc_count, int'(cfg.channels));
			end
			if (rd_valid) begin
				if (exp_q.size() == 0) begin
					status_errors++;
					$display("rd_valid came with no host read outstanding at t=%0t", $time);
				end else begin
					exp_word = exp_q.pop_front();
					exp_addr = addr_q.pop_front();
					check_pix_lanes($sformatf("rd_data @ %0d", exp_addr), rd_data, exp_word);
				end
			end
			if (next_channel) begin
				nc_count++;
			end
			if (start) begin
				start_cycle = cycle;
				end_cycle = NEVER;
				nc_count = 0;
			end
			if (mac_valid && final_beat) begin
				end_cycle = cycle + `ACC_LAT;
			end
			if (rd_en) begin
				rd_en_cycle = cycle;
			end
		end
	end

	initial begin
		do @(posedge clk); while (cycle < limit);
		$display("run did not finish within %0d cycles", limit);
		$display("errors: data %0d, status %0d", data_errors, status_errors);
		$display("Some tests failed");
		$finish;
	end

	// ##################################################################
	// main sequence
	// ##################################################################

	initial begin
		cfg_t l1;
		cfg_t l2;
		cfg_t l3;
		int all_beats;
		int all_words;
		seed = 59;
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		cfg = '0;
		mac_valid = 1'b0;
		mac_result = '0;
		rd_en = 1'b0;
		rd_addr = '0;
		chan_end = 1'b0;
		final_beat = 1'b0;

		// one channel, ReLU right away
		l1 = '0;
		l1.channels = 8'd1;
		l1.row_len = 8'd4;
		l1.groups = 8'd3;
		l1.n = 8'd4;
		l1.frac = 8'd100;
		l1.bias = $random(seed) % 4096;
		l1.base = 8'd16;

		// three channels, gaps and clamping
		l2 = '0;
		l2.channels = 8'd3;
		l2.row_len = 8'd5;
		l2.groups = 8'd2;
		l2.n = 8'd2;
		l2.frac = 8'd200;
		l2.bias = $random(seed) % 4096;
		l2.base = 8'd64;

		// overlaps the upper part of l1
		l3 = '0;
		l3.channels = 8'd2;
		l3.row_len = 8'd4;
		l3.groups = 8'd2;
		l3.n = 8'd3;
		l3.frac = 8'd150;
		l3.bias = $random(seed) % 4096;
		l3.base = 8'd20;

		// words read back, each readback covers the earlier layers too
		all_words = 12 + (12 + 10) + (12 + 10);
		all_beats = 1 * 12 + 3 * 10 + 2 * 8;
		// gaps add at most two cycles per beat, a read takes three
		limit = 200 + 3 * all_beats + 3 * all_words;

		repeat (5) @(posedge clk);
		rst <= 1'b0;
		// idle outputs stay low
		repeat (8) @(posedge clk);

		run_layer(l1, 1'b0, 1'b0);
		read_set();
		run_layer(l2, 1'b1, 1'b1);
		read_set();
		run_layer(l3, 1'b0, 1'b0);
		read_set();

		repeat (4) @(posedge clk);
		@(negedge clk);
		if (exp_q.size() != 0) begin
			status_errors++;
			$display("%0d host reads never returned data", exp_q.size());
		end
		$display("errors: data %0d, status %0d", data_errors, status_errors);
		if (data_errors == 0 && status_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
+incdir+tb
hw/conv_types_pkg.sv
hw/of_bus_pkg.sv
hw/of_bus_if.sv
hw/layer_sequencer.sv
hw/requant_lanes.sv
hw/of_accumulator.sv
hw/of_store.sv
hw/host_readout.sv
hw/conv_out_top.sv
tb/conv_out_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module conv_out_tb -f vlog.f

./obj_dir/Vconv_out_tb | tee sim.log

if grep -qx "All tests passed" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
